// File: verilog/vmul_pkg.sv
// ========================================
// Vector multiply unit definitions
// Widths, queue depths, pipeline latency and
// the opcode and element-width encodings
// ========================================
`default_nettype none

package vmul_pkg;

  // Datapath
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = ElenWidth / 8;

  // Instruction ids and vector length
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned IdWidth = $clog2(NrVInsn);
  localparam int unsigned VlWidth = 7;

  // Register file addressing, vd * VRegWords + word index
  localparam int unsigned VRegWords = 8;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned VdWidth   = AddrWidth - $clog2(VRegWords);

  // Queues
  localparam int unsigned VInsnQueueDepth  = 4;
  localparam int unsigned VInsnPtrWidth    = $clog2(VInsnQueueDepth);
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned ResPtrWidth      = $clog2(ResultQueueDepth);

  // Multiplier pipeline stages
  localparam int unsigned MulLatency = 2;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMACC  = 2'd1,
    VNMSAC = 2'd2
  } mul_op_e;

endpackage

`default_nettype wire

// File: verilog/vmul_decode.sv
// ========================================
// Vector multiply decode
// Holds accepted instructions and issues one
// tagged operand word per cycle to the multiplier
// ========================================
`timescale 1ns/1ps
`default_nettype none

module vmul_decode import vmul_pkg::*; (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          vinsn_valid_i,
  output logic                               vinsn_ready_o,
  input  wire mul_op_e                       vinsn_op_i,
  input  wire vew_e                          vinsn_vsew_i,
  input  wire logic [VlWidth-1:0]            vinsn_vl_i,
  input  wire logic [VdWidth-1:0]            vinsn_vd_i,
  input  wire logic [IdWidth-1:0]            vinsn_id_i,
  input  wire logic                          vinsn_use_scalar_i,
  input  wire logic [ElenWidth-1:0]          vinsn_scalar_i,
  input  wire logic [2:0][ElenWidth-1:0]     operand_i,
  input  wire logic [2:0]                    operand_valid_i,
  output logic      [2:0]                    operand_ready_o,
  output logic                               mul_valid_o,
  input  wire logic                          mul_ready_i,
  output logic      [ElenWidth-1:0]          mul_a_o,
  output logic      [ElenWidth-1:0]          mul_b_o,
  output logic      [ElenWidth-1:0]          mul_c_o,
  output mul_op_e                            mul_op_o,
  output vew_e                               mul_vsew_o,
  output logic      [IdWidth-1:0]            tag_id_o,
  output logic      [AddrWidth-1:0]          tag_addr_o,
  output logic      [StrbWidth-1:0]          tag_be_o,
  output logic                               tag_last_o
);

  // Instruction storage
  mul_op_e              q_op         [VInsnQueueDepth];
  vew_e                 q_vsew       [VInsnQueueDepth];
  logic [VlWidth-1:0]   q_vl         [VInsnQueueDepth];
  logic [VdWidth-1:0]   q_vd         [VInsnQueueDepth];
  logic [IdWidth-1:0]   q_id         [VInsnQueueDepth];
  logic                 q_use_scalar [VInsnQueueDepth];
  logic [ElenWidth-1:0] q_scalar     [VInsnQueueDepth];

  logic [VInsnPtrWidth-1:0] accept_pnt_q, issue_pnt_q;
  logic [VInsnPtrWidth:0]   cnt_q;
  // Elements of the head instruction already sent
  logic [VlWidth-1:0]       issued_q;

  logic                 head_valid;
  mul_op_e              head_op;
  vew_e                 head_vsew;
  logic                 head_use_scalar;
  logic [ElenWidth-1:0] scalar_rep;
  logic [2:0]           used;
  logic                 operands_valid;
  logic                 accept, issue, pop;
  logic [3:0]           elems_per_word, issue_elems, issue_bytes;
  logic [VlWidth-1:0]   remaining, word_idx;

  assign head_valid      = (cnt_q != '0);
  assign head_op         = q_op[issue_pnt_q];
  assign head_vsew       = q_vsew[issue_pnt_q];
  assign head_use_scalar = q_use_scalar[issue_pnt_q];

  assign vinsn_ready_o = (cnt_q != (VInsnPtrWidth+1)'(VInsnQueueDepth));
  assign accept        = vinsn_valid_i && vinsn_ready_o;

  // vd feeds only the accumulating ops and vs1 is skipped for a scalar
  assign used           = {head_op != VMUL, 1'b1, !head_use_scalar};
  assign operands_valid = &(operand_valid_i | ~used);

  assign mul_valid_o     = head_valid && operands_valid;
  assign issue           = mul_valid_o && mul_ready_i;
  assign operand_ready_o = issue ? used : 3'b000;

  // Replicate the scalar element over the whole word
  always_comb begin
    case (head_vsew)
      EW8:     scalar_rep = {8{q_scalar[issue_pnt_q][7:0]}};
      EW16:    scalar_rep = {4{q_scalar[issue_pnt_q][15:0]}};
      EW32:    scalar_rep = {2{q_scalar[issue_pnt_q][31:0]}};
      default: scalar_rep = q_scalar[issue_pnt_q];
    endcase
  end

  assign mul_a_o    = head_use_scalar ? scalar_rep : operand_i[0];
  assign mul_b_o    = operand_i[1];
  assign mul_c_o    = operand_i[2];
  assign mul_op_o   = head_op;
  assign mul_vsew_o = head_vsew;

  // Element bookkeeping for the word being issued
  assign elems_per_word = 4'(StrbWidth >> head_vsew);
  assign remaining      = q_vl[issue_pnt_q] - issued_q;
  assign tag_last_o     = (remaining <= VlWidth'(elems_per_word));
  assign issue_elems    = tag_last_o ? remaining[3:0] : elems_per_word;
  assign issue_bytes    = 4'(issue_elems << head_vsew);
  assign word_idx       = issued_q >> (3 - int'(head_vsew));

  always_comb begin
    for (int b = 0; b < StrbWidth; b++) begin
      tag_be_o[b] = (4'(b) < issue_bytes);
    end
  end

  assign tag_id_o   = q_id[issue_pnt_q];
  assign tag_addr_o = AddrWidth'(q_vd[issue_pnt_q] * VRegWords + word_idx);

  assign pop = issue && tag_last_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      cnt_q        <= '0;
      issued_q     <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (pop) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
        issued_q    <= '0;
      end else if (issue) begin
        issued_q <= issued_q + VlWidth'(issue_elems);
      end
      if (accept && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !accept) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      q_op[accept_pnt_q]         <= vinsn_op_i;
      q_vsew[accept_pnt_q]       <= vinsn_vsew_i;
      q_vl[accept_pnt_q]         <= vinsn_vl_i;
      q_vd[accept_pnt_q]         <= vinsn_vd_i;
      q_id[accept_pnt_q]         <= vinsn_id_i;
      q_use_scalar[accept_pnt_q] <= vinsn_use_scalar_i;
      q_scalar[accept_pnt_q]     <= vinsn_scalar_i;
    end
  end

  // Accepted vector lengths lie between one and 64 elements
  a_vl_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (vinsn_vl_i != '0) && (vinsn_vl_i <= VlWidth'(64)));

endmodule

`default_nettype wire

// File: verilog/vmul_simd_mul.sv
// ========================================
// SIMD multiply-accumulate pipeline
// 8/16/32/64-bit lanes, stalls as a whole
// ========================================
`timescale 1ns/1ps
`default_nettype none

module vmul_simd_mul import vmul_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 in_valid_i,
  output logic                      in_ready_o,
  input  wire logic [ElenWidth-1:0] a_i,
  input  wire logic [ElenWidth-1:0] b_i,
  input  wire logic [ElenWidth-1:0] c_i,
  input  wire mul_op_e              op_i,
  input  wire vew_e                 vsew_i,
  input  wire logic [IdWidth-1:0]   tag_id_i,
  input  wire logic [AddrWidth-1:0] tag_addr_i,
  input  wire logic [StrbWidth-1:0] tag_be_i,
  input  wire logic                 tag_last_i,
  output logic                      out_valid_o,
  input  wire logic                 out_ready_i,
  output logic      [ElenWidth-1:0] result_o,
  output logic      [IdWidth-1:0]   tag_id_o,
  output logic      [AddrWidth-1:0] tag_addr_o,
  output logic      [StrbWidth-1:0] tag_be_o,
  output logic                      tag_last_o
);

  // Results for every element width, selected by vsew
  logic [3:0][ElenWidth-1:0] ew_res;
  logic [ElenWidth-1:0]      mac_res;

  for (genvar w = 0; w < 4; w++) begin : gen_ew
    localparam int unsigned EW = 8 << w;
    for (genvar e = 0; e < ElenWidth / EW; e++) begin : gen_lane
      logic [EW-1:0] prod;
      assign prod = a_i[EW*e +: EW] * b_i[EW*e +: EW];
      assign ew_res[w][EW*e +: EW] = (op_i == VMACC)  ? c_i[EW*e +: EW] + prod :
                                     (op_i == VNMSAC) ? c_i[EW*e +: EW] - prod :
                                     prod;
    end
  end

  assign mac_res = ew_res[vsew_i];

  logic [MulLatency-1:0] valid_q;
  logic [ElenWidth-1:0]  data_q [MulLatency];
  logic [IdWidth-1:0]    id_q   [MulLatency];
  logic [AddrWidth-1:0]  addr_q [MulLatency];
  logic [StrbWidth-1:0]  be_q   [MulLatency];
  logic                  last_q [MulLatency];
  logic                  stall;

  // Only a full output stage that is not drained holds the pipe
  assign stall      = valid_q[MulLatency-1] && !out_ready_i;
  assign in_ready_o = !stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= in_valid_i;
      for (int s = 1; s < MulLatency; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      data_q[0] <= mac_res;
      id_q[0]   <= tag_id_i;
      addr_q[0] <= tag_addr_i;
      be_q[0]   <= tag_be_i;
      last_q[0] <= tag_last_i;
      for (int s = 1; s < MulLatency; s++) begin
        data_q[s] <= data_q[s-1];
        id_q[s]   <= id_q[s-1];
        addr_q[s] <= addr_q[s-1];
        be_q[s]   <= be_q[s-1];
        last_q[s] <= last_q[s-1];
      end
    end
  end

  assign out_valid_o = valid_q[MulLatency-1];
  assign result_o    = data_q[MulLatency-1];
  assign tag_id_o    = id_q[MulLatency-1];
  assign tag_addr_o  = addr_q[MulLatency-1];
  assign tag_be_o    = be_q[MulLatency-1];
  assign tag_last_o  = last_q[MulLatency-1];

  // A word offered downstream must wait unchanged for its ready
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(result_o) && $stable(tag_addr_o) &&
      $stable(tag_id_o) && $stable(tag_be_o) && $stable(tag_last_o));

endmodule

`default_nettype wire

// File: verilog/vmul_result.sv
// ========================================
// Vector multiply result queue
// Writes words to the register file and
// reports finished instructions
// ========================================
`timescale 1ns/1ps
`default_nettype none

module vmul_result import vmul_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 in_valid_i,
  output logic                      in_ready_o,
  input  wire logic [ElenWidth-1:0] wdata_i,
  input  wire logic [IdWidth-1:0]   tag_id_i,
  input  wire logic [AddrWidth-1:0] tag_addr_i,
  input  wire logic [StrbWidth-1:0] tag_be_i,
  input  wire logic                 tag_last_i,
  output logic                      result_req_o,
  output logic      [AddrWidth-1:0] result_addr_o,
  output logic      [ElenWidth-1:0] result_wdata_o,
  output logic      [StrbWidth-1:0] result_be_o,
  input  wire logic                 result_gnt_i,
  output logic      [NrVInsn-1:0]   vinsn_done_o
);

  logic [ElenWidth-1:0] wdata_q [ResultQueueDepth];
  logic [IdWidth-1:0]   id_q    [ResultQueueDepth];
  logic [AddrWidth-1:0] addr_q  [ResultQueueDepth];
  logic [StrbWidth-1:0] be_q    [ResultQueueDepth];
  logic                 last_q  [ResultQueueDepth];

  logic [ResPtrWidth-1:0] rd_pnt_q, wr_pnt_q;
  logic [ResPtrWidth:0]   cnt_q;
  logic                   push, pop;

  assign in_ready_o = (cnt_q != (ResPtrWidth+1)'(ResultQueueDepth));
  assign push       = in_valid_i && in_ready_o;

  // Head entry goes to the register file until granted
  assign result_req_o   = (cnt_q != '0);
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];
  assign pop            = result_req_o && result_gnt_i;

  always_comb begin
    vinsn_done_o = '0;
    if (pop && last_q[rd_pnt_q]) begin
      vinsn_done_o[id_q[rd_pnt_q]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      wdata_q[wr_pnt_q] <= wdata_i;
      id_q[wr_pnt_q]    <= tag_id_i;
      addr_q[wr_pnt_q]  <= tag_addr_i;
      be_q[wr_pnt_q]    <= tag_be_i;
      last_q[wr_pnt_q]  <= tag_last_i;
    end
  end

  // Register file only grants a pending request
  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o);

endmodule

`default_nettype wire

// File: verilog/vmul_unit.sv
// ========================================
// Vector lane integer multiply unit
// Decode, SIMD multiplier and result queue
// ========================================
`timescale 1ns/1ps
`default_nettype none

module vmul_unit import vmul_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      vinsn_valid_i,
  output logic                           vinsn_ready_o,
  input  wire mul_op_e                   vinsn_op_i,
  input  wire vew_e                      vinsn_vsew_i,
  input  wire logic [VlWidth-1:0]        vinsn_vl_i,
  input  wire logic [VdWidth-1:0]        vinsn_vd_i,
  input  wire logic [IdWidth-1:0]        vinsn_id_i,
  input  wire logic                      vinsn_use_scalar_i,
  input  wire logic [ElenWidth-1:0]      vinsn_scalar_i,
  input  wire logic [2:0][ElenWidth-1:0] operand_i,
  input  wire logic [2:0]                operand_valid_i,
  output logic      [2:0]                operand_ready_o,
  output logic                           result_req_o,
  output logic      [AddrWidth-1:0]      result_addr_o,
  output logic      [ElenWidth-1:0]      result_wdata_o,
  output logic      [StrbWidth-1:0]      result_be_o,
  input  wire logic                      result_gnt_i,
  output logic      [NrVInsn-1:0]        vinsn_done_o
);

  // Decode to multiplier
  logic                 mul_valid, mul_ready;
  logic [ElenWidth-1:0] mul_a, mul_b, mul_c;
  mul_op_e              mul_op;
  vew_e                 mul_vsew;
  logic [IdWidth-1:0]   tag_id;
  logic [AddrWidth-1:0] tag_addr;
  logic [StrbWidth-1:0] tag_be;
  logic                 tag_last;

  // Multiplier to result queue
  logic                 res_valid, res_ready;
  logic [ElenWidth-1:0] res_wdata;
  logic [IdWidth-1:0]   res_id;
  logic [AddrWidth-1:0] res_addr;
  logic [StrbWidth-1:0] res_be;
  logic                 res_last;

  vmul_decode decode (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .vinsn_valid_i      (vinsn_valid_i),
    .vinsn_ready_o      (vinsn_ready_o),
    .vinsn_op_i         (vinsn_op_i),
    .vinsn_vsew_i       (vinsn_vsew_i),
    .vinsn_vl_i         (vinsn_vl_i),
    .vinsn_vd_i         (vinsn_vd_i),
    .vinsn_id_i         (vinsn_id_i),
    .vinsn_use_scalar_i (vinsn_use_scalar_i),
    .vinsn_scalar_i     (vinsn_scalar_i),
    .operand_i          (operand_i),
    .operand_valid_i    (operand_valid_i),
    .operand_ready_o    (operand_ready_o),
    .mul_valid_o        (mul_valid),
    .mul_ready_i        (mul_ready),
    .mul_a_o            (mul_a),
    .mul_b_o            (mul_b),
    .mul_c_o            (mul_c),
    .mul_op_o           (mul_op),
    .mul_vsew_o         (mul_vsew),
    .tag_id_o           (tag_id),
    .tag_addr_o         (tag_addr),
    .tag_be_o           (tag_be),
    .tag_last_o         (tag_last)
  );

  vmul_simd_mul execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (mul_valid),
    .in_ready_o  (mul_ready),
    .a_i         (mul_a),
    .b_i         (mul_b),
    .c_i         (mul_c),
    .op_i        (mul_op),
    .vsew_i      (mul_vsew),
    .tag_id_i    (tag_id),
    .tag_addr_i  (tag_addr),
    .tag_be_i    (tag_be),
    .tag_last_i  (tag_last),
    .out_valid_o (res_valid),
    .out_ready_i (res_ready),
    .result_o    (res_wdata),
    .tag_id_o    (res_id),
    .tag_addr_o  (res_addr),
    .tag_be_o    (res_be),
    .tag_last_o  (res_last)
  );

  vmul_result result (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (res_valid),
    .in_ready_o     (res_ready),
    .wdata_i        (res_wdata),
    .tag_id_i       (res_id),
    .tag_addr_i     (res_addr),
    .tag_be_i       (res_be),
    .tag_last_i     (res_last),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_vmul_tasks.svh
// ========================================
// Directed tests and reference model
// for the vector multiply unit
// ========================================

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    $display("Regression failed");
    $fatal(1);
  end
endtask

task automatic fail_now(input string msg);
  $display("%s", msg);
  $display("Regression failed");
  $fatal(1);
endtask

// Element-wise multiply with optional accumulate keeping the low bits
function automatic logic [63:0] lanes_op(input logic [63:0] a, input logic [63:0] b,
                                         input logic [63:0] c, input mul_op_e op,
                                         input vew_e ew);
  logic [63:0] res, mask, ae, bel, ce, p, r;
  int          w;
  w    = 8 << ew;
  mask = (w == 64) ? 64'hffff_ffff_ffff_ffff : ((64'd1 << w) - 64'd1);
  res  = '0;
  for (int e = 0; e < 64 / w; e++) begin
    ae  = (a >> (w * e)) & mask;
    bel = (b >> (w * e)) & mask;
    ce  = (c >> (w * e)) & mask;
    p   = (ae * bel) & mask;
    r   = (op == VMACC) ? ce + p : (op == VNMSAC) ? ce - p : p;
    res = res | ((r & mask) << (w * e));
  end
  return res;
endfunction

function automatic logic [63:0] replicate(input logic [63:0] x, input vew_e ew);
  logic [63:0] res, mask;
  int          w;
  w    = 8 << ew;
  mask = (w == 64) ? 64'hffff_ffff_ffff_ffff : ((64'd1 << w) - 64'd1);
  res  = '0;
  for (int e = 0; e < 64 / w; e++) begin
    res = res | ((x & mask) << (w * e));
  end
  return res;
endfunction

// Queues one instruction, its operand words and its expected writes
task automatic push_insn(input mul_op_e op, input vew_e ew, input int vl, input int vd,
                         input logic use_scalar);
  logic [63:0] a, b, c, scalar;
  logic [7:0]  be, addr;
  logic [2:0]  id;
  int          epw, nwords, rem, nel;
  id     = 3'(next_id);
  next_id++;
  scalar = {$random(seed), $random(seed)};
  epw    = 8 >> ew;
  nwords = (vl + epw - 1) / epw;
  rem    = vl;
  for (int w = 0; w < nwords; w++) begin
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    c = {$random(seed), $random(seed)};
    if (use_scalar) a = replicate(scalar, ew);
    else opq0.push_back(a);
    opq1.push_back(b);
    if (op != VMUL) opq2.push_back(c);
    nel  = (rem < epw) ? rem : epw;
    be   = 8'((16'd1 << (nel << ew)) - 16'd1);
    addr = 8'(vd * 8 + w);
    exp_q.push_back({w == nwords - 1, id, addr, be, lanes_op(a, b, c, op, ew)});
    rem -= nel;
  end
  ins_q.push_back({op, ew, 7'(vl), 5'(vd), id, use_scalar, scalar});
  cycle_limit += 12 * nwords + 10;
endtask

task automatic drain();
  while (exp_q.size() != 0) @(posedge clk_i);
  if (opq0.size() != 0 || opq1.size() != 0 || opq2.size() != 0) begin
    fail_now("Operand words were left unconsumed after all writes");
  end
endtask

task automatic reset_state();
  check_val("vinsn_ready_o", 64'(vinsn_ready_o), 64'd1);
  check_val("result_req_o", 64'(result_req_o), 64'd0);
  check_val("vinsn_done_o", 64'(vinsn_done_o), 64'd0);
  check_val("operand_ready_o", 64'(operand_ready_o), 64'd0);
endtask

task automatic vmul_each_width();
  gnt_mode = 1;
  for (int ew = 0; ew < 4; ew++) begin
    push_insn(VMUL, vew_e'(ew), 2 * (8 >> ew), ew + 1, 1'b0);
  end
  drain();
endtask

task automatic scalar_operand();
  gnt_mode = 2;
  push_insn(VMUL, EW8, 16, 6, 1'b1);
  push_insn(VMUL, EW16, 8, 7, 1'b1);
  drain();
endtask

task automatic accumulate_ops();
  push_insn(VMACC, EW32, 4, 8, 1'b0);
  push_insn(VNMSAC, EW8, 16, 9, 1'b0);
  push_insn(VMACC, EW64, 3, 10, 1'b0);
  push_insn(VNMSAC, EW16, 8, 11, 1'b0);
  drain();
endtask

task automatic partial_last_word();
  push_insn(VMUL, EW16, 5, 3, 1'b0);
  push_insn(VMACC, EW8, 13, 4, 1'b1);
  drain();
endtask

task automatic grant_backpressure();
  gnt_mode = 0;
  cycle_limit += 30;
  @(posedge clk_i);
  saw_full <= 1'b0;
  for (int i = 0; i < 5; i++) begin
    push_insn(VMUL, EW64, 8, 12 + i, 1'b0);
  end
  repeat (30) @(posedge clk_i);
  if (!saw_full) fail_now("Instruction queue never filled while grants were held");
  gnt_mode = 2;
  drain();
endtask

// File: tests/tb_vmul_unit.sv
// ========================================
// Vector multiply unit testbench
// Drives instructions and operands, models the
// expected register-file writes and checks them
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_vmul_unit;
  import vmul_pkg::*;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      vinsn_valid_i;
  logic                      vinsn_ready_o;
  mul_op_e                   vinsn_op_i;
  vew_e                      vinsn_vsew_i;
  logic [VlWidth-1:0]        vinsn_vl_i;
  logic [VdWidth-1:0]        vinsn_vd_i;
  logic [IdWidth-1:0]        vinsn_id_i;
  logic                      vinsn_use_scalar_i;
  logic [ElenWidth-1:0]      vinsn_scalar_i;
  logic [2:0][ElenWidth-1:0] operand_i;
  logic [2:0]                operand_valid_i;
  logic [2:0]                operand_ready_o;
  logic                      result_req_o;
  logic [AddrWidth-1:0]      result_addr_o;
  logic [ElenWidth-1:0]      result_wdata_o;
  logic [StrbWidth-1:0]      result_be_o;
  logic                      result_gnt_i;
  logic [NrVInsn-1:0]        vinsn_done_o;

  // Pending stimulus and expected writes
  // Instruction entry is {op, ew, vl, vd, id, use_scalar, scalar}
  logic [83:0] ins_q [$];
  // Expected entry is {last, id, addr, be, data}
  logic [83:0] exp_q [$];
  logic [63:0] opq0 [$];
  logic [63:0] opq1 [$];
  logic [63:0] opq2 [$];

  int   seed = 32'hefe9_ea08;
  int   cycles = 0;
  int   cycle_limit = 100;
  int   gnt_mode = 1;
  int   next_id = 0;
  logic gnt_allow;
  logic saw_full;

  vmul_unit dut0 (.*);

  // Grant only ever follows a pending request
  assign result_gnt_i = gnt_allow && result_req_o;

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d writes still expected", cycles, exp_q.size());
      $display("Regression failed");
      $fatal(1);
    end
  end

  // Instruction source
  always @(posedge clk_i) begin
    logic [83:0] e;
    if (vinsn_valid_i && vinsn_ready_o) begin
      void'(ins_q.pop_front());
    end
    if (!vinsn_ready_o) begin
      saw_full <= 1'b1;
    end
    e = (ins_q.size() != 0) ? ins_q[0] : '0;
    vinsn_valid_i      <= (ins_q.size() != 0);
    vinsn_op_i         <= mul_op_e'(e[83:82]);
    vinsn_vsew_i       <= vew_e'(e[81:80]);
    vinsn_vl_i         <= e[79:73];
    vinsn_vd_i         <= e[72:68];
    vinsn_id_i         <= e[67:65];
    vinsn_use_scalar_i <= e[64];
    vinsn_scalar_i     <= e[63:0];
  end

  // Operand queues vs1, vs2 and vd
  always @(posedge clk_i) begin
    if (|(operand_ready_o & ~operand_valid_i)) begin
      fail_now("An operand queue was acknowledged while it held no word");
    end
    if (operand_ready_o[0]) void'(opq0.pop_front());
    if (operand_ready_o[1]) void'(opq1.pop_front());
    if (operand_ready_o[2]) void'(opq2.pop_front());
    operand_valid_i <= {opq2.size() != 0, opq1.size() != 0, opq0.size() != 0};
    operand_i[0]    <= (opq0.size() != 0) ? opq0[0] : 64'd0;
    operand_i[1]    <= (opq1.size() != 0) ? opq1[0] : 64'd0;
    operand_i[2]    <= (opq2.size() != 0) ? opq2[0] : 64'd0;
  end

  // Register-file sink
  always @(posedge clk_i) begin
    logic [83:0] e;
    int          r;
    if (result_req_o && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        fail_now("Register file write arrived with none expected");
      end
      e = exp_q.pop_front();
      check_val("result_addr_o", 64'(result_addr_o), 64'(e[79:72]));
      check_val("result_wdata_o", result_wdata_o, e[63:0]);
      check_val("result_be_o", 64'(result_be_o), 64'(e[71:64]));
      check_val("vinsn_done_o", 64'(vinsn_done_o),
                e[83] ? (64'd1 << e[82:80]) : 64'd0);
    end else begin
      check_val("vinsn_done_o", 64'(vinsn_done_o), 64'd0);
    end
    r = $random(seed);
    gnt_allow <= (gnt_mode == 1) || (gnt_mode == 2 && r[0]);
  end

  initial begin
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    vinsn_valid_i      = 1'b0;
    vinsn_op_i         = VMUL;
    vinsn_vsew_i       = EW8;
    vinsn_vl_i         = '0;
    vinsn_vd_i         = '0;
    vinsn_id_i         = '0;
    vinsn_use_scalar_i = 1'b0;
    vinsn_scalar_i     = '0;
    operand_i          = '0;
    operand_valid_i    = '0;
    gnt_allow          = 1'b0;
    saw_full           = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    reset_state();
    vmul_each_width();
    scalar_operand();
    accumulate_ops();
    partial_last_word();
    grant_backpressure();
    $display("Regression passed");
    $finish;
  end

  `include "tb_vmul_tasks.svh"

endmodule

`default_nettype wire

// File: build.f
+incdir+tests
verilog/vmul_pkg.sv
verilog/vmul_decode.sv
verilog/vmul_simd_mul.sv
verilog/vmul_result.sv
verilog/vmul_unit.sv
tests/tb_vmul_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the vector multiply unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_vmul_unit -o sim_vmul \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_vmul > sim.log 2>&1 || true
cat sim.log
grep -q "Regression failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
